// ==== src/procPkg.sv ====
package procPkg;

  localparam int numRegs    = 8;  // R0..R7
  localparam int instrWidth = 9;  // low din bits taken as instruction
  localparam int idxWidth   = 3;  // bits per register index

  // instruction field positions, opcode in the top bits
  localparam int opMsb = 8;
  localparam int opLsb = 6;
  localparam int xMsb  = 5;  // destination / first operand
  localparam int xLsb  = 3;
  localparam int yMsb  = 2;  // source / second operand
  localparam int yLsb  = 0;

  // 100..111 fall outside the enum and act as no-ops
  typedef enum logic [2:0] {
    opMv  = 3'b000,  // Rx <- Ry
    opMvi = 3'b001,  // Rx <- next din word
    opAdd = 3'b010,  // Rx <- Rx + Ry
    opSub = 3'b011   // Rx <- Rx - Ry
  } opcodeT;

  typedef enum logic [1:0] {
    stepT0 = 2'b00,  // idle, waits for run
    stepT1 = 2'b01,
    stepT2 = 2'b10,
    stepT3 = 2'b11
  } stepT;

  typedef logic [idxWidth-1:0]   regIdxT;  // register index
  typedef logic [instrWidth-1:0] instrT;   // opcode | x | y

endpackage

// ==== src/procControl.sv ====
module procControl (
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            run,     // start request, seen only in T0
  input  logic [procPkg::instrWidth-1:0]  din,     // low bits of top-level din
  output logic                            done,    // last step of instruction
  output logic [procPkg::numRegs-1:0]     regIn,   // one-hot register write enable
  output logic [procPkg::numRegs-1:0]     regOut,  // one-hot register bus select
  output logic                            aIn,     // load A from bus
  output logic                            gIn,     // load G from adder
  output logic                            gOut,    // G drives bus
  output logic                            dinOut,  // din drives bus
  output logic                            addSub   // 0 add, 1 subtract
);

  procPkg::stepT   step;      // current step
  procPkg::stepT   stepNext;
  procPkg::instrT  instr;     // instruction register
  procPkg::opcodeT opcode;
  procPkg::regIdxT xIdx;
  procPkg::regIdxT yIdx;
  logic [procPkg::numRegs-1:0] xHot;  // decoded x
  logic [procPkg::numRegs-1:0] yHot;  // decoded y
  logic accept;                       // run taken this cycle
  logic isArith;                      // add or sub

  // instruction fields
  assign opcode = procPkg::opcodeT'(instr[procPkg::opMsb:procPkg::opLsb]);
  assign xIdx   = instr[procPkg::xMsb:procPkg::xLsb];
  assign yIdx   = instr[procPkg::yMsb:procPkg::yLsb];

  assign accept  = (step == procPkg::stepT0) && run;  // busy steps ignore run
  assign isArith = (opcode == procPkg::opAdd) || (opcode == procPkg::opSub);

  // register index to one-hot
  always_comb begin
    xHot       = '0;
    yHot       = '0;
    xHot[xIdx] = 1'b1;
    yHot[yIdx] = 1'b1;
  end

  // instruction register
  always_ff @(posedge clock) begin
    if (!rstN) begin
      instr <= '0;
    end else if (accept) begin
      instr <= din;  // captured on the run edge
    end
  end

  // step counter
  always_comb begin
    stepNext = step;
    if (accept) begin
      stepNext = procPkg::stepT1;
    end else if (done) begin
      stepNext = procPkg::stepT0;  // back to idle after done cycle
    end else if (step != procPkg::stepT0) begin
      stepNext = procPkg::stepT'(step + 2'd1);
    end
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      step <= procPkg::stepT0;
    end else begin
      step <= stepNext;
    end
  end

  // control decode, all low in T0
  always_comb begin
    done   = 1'b0;
    regIn  = '0;
    regOut = '0;
    aIn    = 1'b0;
    gIn    = 1'b0;
    gOut   = 1'b0;
    dinOut = 1'b0;
    addSub = 1'b0;
    case (step)
      procPkg::stepT1: begin
        case (opcode)
          procPkg::opMv: begin
            regOut = yHot;  // Ry onto bus
            regIn  = xHot;  // into Rx
            done   = 1'b1;
          end
          procPkg::opMvi: begin
            dinOut = 1'b1;  // immediate word on din
            regIn  = xHot;
            done   = 1'b1;
          end
          procPkg::opAdd,
          procPkg::opSub: begin
            regOut = xHot;  // first operand into A
            aIn    = 1'b1;
          end
          default: begin
            done = 1'b1;    // no-op, nothing written
          end
        endcase
      end
      procPkg::stepT2: begin
        if (isArith) begin
          regOut = yHot;    // second operand straight to adder
          gIn    = 1'b1;
          addSub = (opcode == procPkg::opSub);
        end
      end
      procPkg::stepT3: begin
        if (isArith) begin
          gOut  = 1'b1;     // result back over bus
          regIn = xHot;
          done  = 1'b1;
        end
      end
      default: begin
        done = 1'b0;        // idle
      end
    endcase
  end

endmodule

// ==== src/regBank.sv ====
module regBank #(
  parameter int dataWidth = 16
) (
  input  logic                                   clock,
  input  logic                                   rstN,
  input  logic [dataWidth-1:0]                   bus,     // shared bus
  input  logic [procPkg::numRegs-1:0]            regIn,   // one-hot write enable
  output logic [procPkg::numRegs*dataWidth-1:0]  regData  // R7..R0 packed, R0 lowest
);

  logic [dataWidth-1:0] regs [procPkg::numRegs];  // R0..R7

  // write from bus at end of enabled cycle
  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < procPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < procPkg::numRegs; i++) begin
        if (regIn[i]) begin
          regs[i] <= bus;
        end
      end
    end
  end

  // every register presented to the bus mux
  for (genvar g = 0; g < procPkg::numRegs; g++) begin : gPack
    assign regData[g*dataWidth +: dataWidth] = regs[g];
  end

endmodule

// ==== src/addSubUnit.sv ====
module addSubUnit #(
  parameter int dataWidth = 16
) (
  input  logic                 clock,
  input  logic                 rstN,
  input  logic [dataWidth-1:0] bus,     // second operand in T2
  input  logic                 aIn,     // load A
  input  logic                 gIn,     // load G
  input  logic                 addSub,  // 0 add, 1 subtract
  output logic [dataWidth-1:0] gData    // G toward bus mux
);

  logic [dataWidth-1:0] aReg;    // first operand
  logic [dataWidth-1:0] gReg;    // result
  logic [dataWidth-1:0] result;  // wraps mod 2^dataWidth

  assign result = addSub ? (aReg - bus) : (aReg + bus);

  always_ff @(posedge clock) begin
    if (!rstN) begin
      aReg <= '0;
      gReg <= '0;
    end else begin
      if (aIn) begin
        aReg <= bus;  // T1 of add/sub
      end
      if (gIn) begin
        gReg <= result;  // T2 of add/sub
      end
    end
  end

  assign gData = gReg;

endmodule

// ==== src/busMux.sv ====
module busMux #(
  parameter int dataWidth = 16
) (
  input  logic [procPkg::numRegs-1:0]            regOut,   // one-hot register select
  input  logic [procPkg::numRegs*dataWidth-1:0]  regData,  // packed R0..R7
  input  logic                                   gOut,     // select G
  input  logic [dataWidth-1:0]                   gData,
  input  logic                                   dinOut,   // select din
  input  logic [dataWidth-1:0]                   din,
  output logic [dataWidth-1:0]                   bus
);

  // and-or over ten sources
  // zero when nothing selected
  always_comb begin
    bus = '0;
    for (int i = 0; i < procPkg::numRegs; i++) begin
      bus |= regData[i*dataWidth +: dataWidth] & {dataWidth{regOut[i]}};
    end
    bus |= gData & {dataWidth{gOut}};  // adder result
    bus |= din & {dataWidth{dinOut}};  // mvi immediate
  end

endmodule

// ==== src/multicycleProc.sv ====
module multicycleProc #(
  parameter int dataWidth = 16  // word width of datapath
) (
  input  logic                 clock,
  input  logic                 rstN,
  input  logic [dataWidth-1:0] din,   // instruction or immediate
  input  logic                 run,
  output logic                 done,
  output logic [dataWidth-1:0] bus    // shared bus, visible outside
);

  logic [procPkg::numRegs-1:0]           regIn;    // register write enables
  logic [procPkg::numRegs-1:0]           regOut;   // register bus selects
  logic [procPkg::numRegs*dataWidth-1:0] regData;  // packed R0..R7
  logic [dataWidth-1:0]                  gData;    // G register
  logic                                  aIn;
  logic                                  gIn;
  logic                                  gOut;
  logic                                  dinOut;
  logic                                  addSub;

  procControl control_i (
    .clock  (clock),
    .rstN   (rstN),
    .run    (run),
    .din    (din[procPkg::instrWidth-1:0]),  // instruction bits only
    .done   (done),
    .regIn  (regIn),
    .regOut (regOut),
    .aIn    (aIn),
    .gIn    (gIn),
    .gOut   (gOut),
    .dinOut (dinOut),
    .addSub (addSub)
  );

  regBank #(.dataWidth(dataWidth)) regBank_i (
    .clock   (clock),
    .rstN    (rstN),
    .bus     (bus),
    .regIn   (regIn),
    .regData (regData)
  );

  addSubUnit #(.dataWidth(dataWidth)) addSub_i (
    .clock  (clock),
    .rstN   (rstN),
    .bus    (bus),
    .aIn    (aIn),
    .gIn    (gIn),
    .addSub (addSub),
    .gData  (gData)
  );

  busMux #(.dataWidth(dataWidth)) busMux_i (
    .regOut  (regOut),
    .regData (regData),
    .gOut    (gOut),
    .gData   (gData),
    .dinOut  (dinOut),
    .din     (din),
    .bus     (bus)
  );

endmodule

// ==== bench/procClockGen.sv ====
module procClockGen (
  output logic clock,
  output logic rstN
);

  // period 8
  initial begin
    clock = 1'b0;
    forever begin
      #4 clock = ~clock;
    end
  end

  // held low over 4 rising edges, released mid-cycle
  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    rstN = 1'b1;
  end

endmodule

// ==== bench/procCheck_assertions.sv ====
module procCheck_assertions (
  input logic                        clock,
  input logic                        rstN,
  input logic                        done,
  input logic [procPkg::numRegs-1:0] regIn,
  input logic [procPkg::numRegs-1:0] regOut,
  input logic                        gOut,
  input logic                        dinOut,
  input procPkg::stepT               step
);

  // never two drivers on the shared bus
  busSourceOneHot: assert property (
    @(posedge clock) disable iff (!rstN)
    $onehot0({regOut, gOut, dinOut})
  ) else $error("more than one bus source selected");

  // done marks the last step, idle follows
  doneEndsInstr: assert property (
    @(posedge clock) disable iff (!rstN)
    done |=> (step == procPkg::stepT0)
  ) else $error("step did not return to T0 after done");

  // at most one register written per cycle
  regWriteOneHot: assert property (
    @(posedge clock) disable iff (!rstN)
    $onehot0(regIn)
  ) else $error("more than one regIn bit high");

endmodule

bind procControl procCheck_assertions checks_i (
  .clock  (clock),
  .rstN   (rstN),
  .done   (done),
  .regIn  (regIn),
  .regOut (regOut),
  .gOut   (gOut),
  .dinOut (dinOut),
  .step   (step)   // internal step counter
);

// ==== bench/procTb.sv ====
module procTb;

  localparam int dataWidth   = 16;
  localparam int doneTimeout = 10;  // cycles allowed for done

  logic                 clock;
  logic                 rstN;
  logic [dataWidth-1:0] din;
  logic                 run;
  logic                 done;
  logic [dataWidth-1:0] bus;

  logic [7:0][dataWidth-1:0] model;  // reference copy of R7..R0
  logic [dataWidth-1:0]      expBus;       // bus value due in done cycle
  logic                      expectDone;   // an instruction is in flight
  string                     curName;      // test name for error lines
  int                        checks      = 0;
  int                        checkErrors = 0;  // bus value errors
  int                        flowErrors  = 0;  // latency, timeout, stray done
  int                        seed;
  bit                        aborted;          // set on timeout

  procClockGen clockGen_i (
    .clock (clock),
    .rstN  (rstN)
  );

  multicycleProc #(.dataWidth(dataWidth)) dut_i (
    .clock (clock),
    .rstN  (rstN),
    .din   (din),
    .run   (run),
    .done  (done),
    .bus   (bus)
  );

  // bus value in the done cycle, from the instruction rules
  function automatic logic [dataWidth-1:0] expectedResult(
    input logic [2:0]                op,
    input procPkg::regIdxT           x,
    input procPkg::regIdxT           y,
    input logic [dataWidth-1:0]      imm,
    input logic [7:0][dataWidth-1:0] regs
  );
    logic [dataWidth-1:0] value;
    case (op)
      procPkg::opMv:  value = regs[y];
      procPkg::opMvi: value = imm;
      procPkg::opAdd: value = regs[x] + regs[y];  // wraps mod 2^16
      procPkg::opSub: value = regs[x] - regs[y];
      default:        value = '0;  // no-op, nothing selected
    endcase
    return value;
  endfunction

  // one instruction, starting and ending on a falling edge
  task automatic issue(
    input string                name,
    input logic [2:0]           op,
    input procPkg::regIdxT      x,
    input procPkg::regIdxT      y,
    input logic [dataWidth-1:0] imm,
    input bit                   holdRun,  // keep run high while busy
    input logic [dataWidth-1:0] heldDin
  );
    procPkg::instrT       instr;
    logic [dataWidth-1:0] value;
    int                   latency;
    int                   wantLatency;
    if (!aborted) begin
      instr       = {op, x, y};
      value       = expectedResult(op, x, y, imm, model);
      wantLatency = (op == procPkg::opAdd || op == procPkg::opSub) ? 3 : 1;
      curName     = name;
      expBus      = value;
      expectDone <= 1'b1;
      din         = dataWidth'(instr);
      run         = 1'b1;
      @(posedge clock);  // run sampled here
      @(negedge clock);
      if (holdRun) begin
        din = heldDin;  // busy, must not be taken
      end else begin
        run = 1'b0;
        din = imm;  // mvi immediate, ignored by others
      end
      latency = 1;
      while (!done && latency <= doneTimeout) begin
        @(negedge clock);
        latency++;
      end
      if (!done) begin
        flowErrors++;
        aborted = 1'b1;
        $display("%s: done never arrived within %0d cycles", name, doneTimeout);
      end else begin
        if (latency != wantLatency) begin
          flowErrors++;
          $display("MISMATCH %s latency expected %0d actual %0d",
                   name, wantLatency, latency);
        end
        @(posedge clock);  // bus compared on this edge
        expectDone <= 1'b0;
        if (op[2] == 1'b0) begin
          model[x] = value;  // mv, mvi, add, sub all write Rx
        end
        @(negedge clock);
      end
    end
  endtask

  // mv Ri,Ri puts each register on the bus unchanged
  task automatic readBack(input string tag);
    for (int i = 0; i < procPkg::numRegs; i++) begin
      issue($sformatf("%s R%0d", tag, i), procPkg::opMv,
            procPkg::regIdxT'(i), procPkg::regIdxT'(i), '0, 1'b0, '0);
    end
  endtask

  // comparing process
  always @(posedge clock) begin
    if (rstN && done) begin
      if (!expectDone) begin
        checkErrors++;
        $display("done went high with no instruction pending");
      end else begin
        checks++;
        if (bus !== expBus) begin
          checkErrors++;
          $display("MISMATCH %s expected %h actual %h", curName, expBus, bus);
        end
      end
    end
  end

  initial begin
    int                   waitCount;
    procPkg::regIdxT      x;
    procPkg::regIdxT      y;
    logic [2:0]           op;
    logic [dataWidth-1:0] imm;
    seed        = 77;
    din         = '0;
    run         = 1'b0;
    expectDone <= 1'b0;
    model       = '0;
    expBus      = '0;
    curName     = "reset";
    aborted     = 1'b0;

    // reset state, done stays low
    @(negedge clock);
    waitCount = 0;
    while (!rstN && waitCount < 20) begin
      if (done !== 1'b0) begin
        flowErrors++;
        $display("done high during reset");
      end
      @(posedge clock);  // rstN only moves on falling edges
      waitCount++;
    end
    if (!rstN) begin
      flowErrors++;
      aborted = 1'b1;
      $display("reset was never released");
    end
    @(negedge clock);
    repeat (3) begin
      if (done !== 1'b0) begin
        flowErrors++;
        $display("done high before any run");
      end
      @(negedge clock);
    end
    issue("reset mv R1,R0", procPkg::opMv, 3'd1, 3'd0, '0, 1'b0, '0);

    // mvi into every register, then read back
    for (int i = 0; i < procPkg::numRegs; i++) begin
      imm = dataWidth'($random(seed));
      issue($sformatf("mvi R%0d", i), procPkg::opMvi, procPkg::regIdxT'(i),
            3'd0, imm, 1'b0, '0);
    end
    readBack("mvi readback");

    // random copies
    for (int i = 0; i < 12; i++) begin
      x = procPkg::regIdxT'($random(seed));
      y = procPkg::regIdxT'($random(seed));
      issue($sformatf("mv R%0d,R%0d", x, y), procPkg::opMv, x, y, '0, 1'b0, '0);
    end

    // overflow and underflow corners
    issue("mvi R2 max", procPkg::opMvi, 3'd2, 3'd0, 16'hFFFF, 1'b0, '0);
    issue("mvi R3 three", procPkg::opMvi, 3'd3, 3'd0, 16'h0003, 1'b0, '0);
    issue("add overflow", procPkg::opAdd, 3'd2, 3'd3, '0, 1'b0, '0);
    issue("mvi R4 one", procPkg::opMvi, 3'd4, 3'd0, 16'h0001, 1'b0, '0);
    issue("sub underflow", procPkg::opSub, 3'd4, 3'd3, '0, 1'b0, '0);
    issue("add x equals y", procPkg::opAdd, 3'd5, 3'd5, '0, 1'b0, '0);
    issue("sub x equals y", procPkg::opSub, 3'd6, 3'd6, '0, 1'b0, '0);

    // random add/sub pairs
    for (int i = 0; i < 16; i++) begin
      x  = procPkg::regIdxT'($random(seed));
      y  = procPkg::regIdxT'($random(seed));
      op = ($random(seed) % 2 == 0) ? procPkg::opAdd : procPkg::opSub;
      issue($sformatf("arith %0d R%0d,R%0d", op, x, y), op, x, y, '0, 1'b0, '0);
    end
    readBack("arith readback");

    // no-ops write nothing
    for (int k = 4; k < 8; k++) begin
      x   = procPkg::regIdxT'($random(seed));
      y   = procPkg::regIdxT'($random(seed));
      imm = dataWidth'($random(seed));
      issue($sformatf("noop %03b", 3'(k)), 3'(k), x, y, imm, 1'b0, '0);
    end
    readBack("after noop");

    // run held high through an add, mv waits on din meanwhile
    issue("held add", procPkg::opAdd, 3'd1, 3'd2, '0, 1'b1,
          dataWidth'({procPkg::opMv, 3'd3, 3'd1}));
    issue("held follow mv", procPkg::opMv, 3'd3, 3'd1, '0, 1'b0, '0);
    readBack("final readback");

    @(negedge clock);
    $display("checks %0d, value errors %0d, flow errors %0d",
             checks, checkErrors, flowErrors);
    if (checkErrors == 0 && flowErrors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/procPkg.sv
src/procControl.sv
src/regBank.sv
src/addSubUnit.sv
src/busMux.sv
src/multicycleProc.sv
bench/procClockGen.sv
bench/procCheck_assertions.sv
bench/procTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run procTb with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module procTb -Mdir obj_dir -f verilog.f

out=$(./obj_dir/VprocTb)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
